// File: dv/masku_checker.sv
`default_nettype none

module masku_checker #(
  parameter int unsigned  data_width = 64,
  parameter int unsigned  vlen       = 512,
  parameter int unsigned  addr_width = 8,
  localparam int unsigned vl_width   = $clog2(vlen + 1)
) (
  input wire logic                  clk_i,
  input wire logic                  rst_ni,
  input wire logic                  insn_valid_i,
  input wire logic [vl_width-1:0]   insn_vl_i,
  input wire logic                  insn_ready_i,
  input wire logic                  opnd_ready_i,
  input wire logic                  result_req_i,
  input wire logic [addr_width-1:0] result_addr_i,
  input wire logic [data_width-1:0] result_wdata_i,
  input wire logic                  result_gnt_i,
  input wire logic                  done_i
);

  ////////////////////////////////////////////////////////////////////////////
  // Handshake rules
  ////////////////////////////////////////////////////////////////////////////

  // Pending write holds until granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_req_i && !result_gnt_i) |=>
      (result_req_i && $stable(result_addr_i) && $stable(result_wdata_i)))
    else $error("Result request changed before its grant");

  // Done is a single-cycle pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni) done_i |=> !done_i)
    else $error("Done held for more than one cycle");

  // No operands without a held instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(opnd_ready_i && insn_ready_i))
    else $error("Operand ready while no instruction is held");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (insn_valid_i && insn_ready_i) |->
      (insn_vl_i != '0 && insn_vl_i <= vl_width'(vlen)))
    else $error("Instruction accepted with vl out of range");

endmodule

bind masku_top masku_checker #(
  .data_width(data_width),
  .vlen      (vlen),
  .addr_width(addr_width)
) checker0 (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .insn_valid_i  (insn_valid_i),
  .insn_vl_i     (insn_vl_i),
  .insn_ready_i  (insn_ready_o),
  .opnd_ready_i  (opnd_ready_o),
  .result_req_i  (result_req_o),
  .result_addr_i (result_addr_o),
  .result_wdata_i(result_wdata_o),
  .result_gnt_i  (result_gnt_i),
  .done_i        (done_o)
);

`default_nettype wire

// File: dv/masku_tests.svh
`ifndef MASKU_TESTS_SVH
`define MASKU_TESTS_SVH

`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Helpers
////////////////////////////////////////////////////////////////////////////

task automatic abort_run(input string line);
  $display("%s", line);
  $display("TESTS FAILED");
  $fatal(1);
endtask

task automatic fill_operands();
  for (int k = 0; k < words_per_reg; k++) begin
    vs2_a[k]  = rand_word();
    vs1_a[k]  = rand_word();
    old_a[k]  = rand_word();
    mask_a[k] = rand_word();
  end
endtask

// Only called while the result port is idle
task automatic clear_capture();
  wr_addr_q.delete();
  wr_id_q.delete();
  wr_data_q.delete();
endtask

// Entered and left just after a rising edge
task automatic send_insn(
  input logic [op_width-1:0]   op,
  input int                    vl,
  input logic                  vm,
  input logic [vreg_width-1:0] vd,
  input logic [vid_width-1:0]  id
);
  int cycles;
  cycles = 0;
  insn_valid_i <= 1'b1;
  insn_op_i    <= op;
  insn_vl_i    <= vl_width'(vl);
  insn_vm_i    <= vm;
  insn_vd_i    <= vd;
  insn_id_i    <= id;
  do begin
    @(posedge clk_i);
    cycles++;
    if (cycles > timeout_cycles) begin
      abort_run("Timeout waiting for the instruction to be accepted");
    end
  end while (!insn_ready_o);
  insn_valid_i <= 1'b0;
endtask

task automatic send_beats(input int nwords);
  int cycles;
  for (int k = 0; k < nwords; k++) begin
    opnd_valid_i <= 1'b1;
    opnd_vs2_i   <= vs2_a[k];
    opnd_vs1_i   <= vs1_a[k];
    opnd_old_i   <= old_a[k];
    opnd_mask_i  <= mask_a[k];
    cycles = 0;
    do begin
      @(posedge clk_i);
      cycles++;
      if (cycles > timeout_cycles) begin
        abort_run($sformatf("Timeout waiting for operand beat %0d to be taken", k));
      end
    end while (!opnd_ready_o);
  end
  opnd_valid_i <= 1'b0;
endtask

// Polls monitor counters away from the rising edge
task automatic wait_done(input int target);
  int cycles;
  cycles = 0;
  do begin
    @(negedge clk_i);
    cycles++;
    if (cycles > timeout_cycles) begin
      abort_run("Timeout waiting for the done pulse");
    end
  end while (done_cnt < target);
  @(posedge clk_i);
endtask

task automatic check_writes(
  input logic [op_width-1:0]   op,
  input int                    vl,
  input logic                  vm,
  input logic [vreg_width-1:0] vd,
  input logic [vid_width-1:0]  id
);
  int                    nwords;
  logic [addr_width-1:0] exp_addr;
  logic [data_width-1:0] exp_data;
  nwords = (vl + int'(data_width) - 1) / int'(data_width);
  assert (wr_data_q.size() == nwords) else
    abort_run($sformatf("Fail at %0t: %0d words written, expected %0d",
                        $time, wr_data_q.size(), nwords));
  for (int k = 0; k < nwords; k++) begin
    exp_addr = addr_width'(int'(vd) * int'(words_per_reg) + k);
    exp_data = ref_word(op, vm, vl - k * int'(data_width),
                        vs2_a[k], vs1_a[k], old_a[k], mask_a[k]);
    assert (wr_addr_q[k] == exp_addr) else
      abort_run($sformatf("Fail at %0t: word %0d address %h, expected %h",
                          $time, k, wr_addr_q[k], exp_addr));
    assert (wr_id_q[k] == id) else
      abort_run($sformatf("Fail at %0t: word %0d id %0d, expected %0d",
                          $time, k, wr_id_q[k], id));
    assert (wr_data_q[k] == exp_data) else
      abort_run($sformatf("Fail at %0t: word %0d data %h, expected %h",
                          $time, k, wr_data_q[k], exp_data));
  end
  // Done must follow the grant of the last word
  assert (writes_at_done == nwords) else
    abort_run($sformatf("Fail at %0t: done after %0d writes, expected %0d",
                        $time, writes_at_done, nwords));
  assert (last_done_id == id) else
    abort_run($sformatf("Fail at %0t: done id %0d, expected %0d",
                        $time, last_done_id, id));
endtask

task automatic run_insn(
  input logic [op_width-1:0]   op,
  input int                    vl,
  input logic                  vm,
  input logic [vreg_width-1:0] vd,
  input logic [vid_width-1:0]  id
);
  int done_base;
  done_base = done_cnt;
  clear_capture();
  send_insn(op, vl, vm, vd, id);
  send_beats((vl + int'(data_width) - 1) / int'(data_width));
  wait_done(done_base + 1);
  check_writes(op, vl, vm, vd, id);
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic test_reset_state();
  assert (insn_ready_o && !opnd_ready_o && !result_req_o && !done_o) else
    abort_run($sformatf("Fail at %0t: reset state ready %b opnd %b req %b done %b",
                        $time, insn_ready_o, opnd_ready_o, result_req_o, done_o));
endtask

task automatic test_all_ops();
  for (int i = 0; i < 8; i++) begin
    fill_operands();
    run_insn(op_width'(i), vlen, 1'b1, vreg_width'(3 + i), vid_width'(i));
  end
endtask

// 100 bits leave bits 36 and up of the second word untouched
task automatic test_tail();
  fill_operands();
  run_insn(op_vmxor, 100, 1'b1, 5'd12, 3'd1);
  assert (wr_data_q[1][63:36] == old_a[1][63:36]) else
    abort_run($sformatf("Fail at %0t: tail bits %h, expected %h",
                        $time, wr_data_q[1][63:36], old_a[1][63:36]));
endtask

task automatic test_masking();
  fill_operands();
  gnt_mode <= gnt_random;
  run_insn(op_vmor, vlen, 1'b0, 5'd17, 3'd4);
  for (int k = 0; k < words_per_reg; k++) begin
    assert (((wr_data_q[k] ^ old_a[k]) & ~mask_a[k]) == '0) else
      abort_run($sformatf("Fail at %0t: word %0d changed masked-off bits",
                          $time, k));
  end
  gnt_mode <= gnt_always;
endtask

task automatic test_back_pressure();
  int beat_base;
  int done_base;
  fill_operands();
  clear_capture();
  beat_base = beat_cnt;
  done_base = done_cnt;
  gnt_mode <= gnt_hold;
  send_insn(op_vmand, vlen, 1'b1, 5'd20, 3'd2);
  fork
    send_beats(words_per_reg);
    begin
      repeat (12) @(negedge clk_i);
      assert (beat_cnt - beat_base <= int'(result_depth)) else
        abort_run($sformatf("Fail at %0t: %0d beats taken without grants",
                            $time, beat_cnt - beat_base));
      gnt_mode <= gnt_random;
    end
  join
  wait_done(done_base + 1);
  check_writes(op_vmand, vlen, 1'b1, 5'd20, 3'd2);
  gnt_mode <= gnt_always;
endtask

task automatic test_done();
  int done_base;
  fill_operands();
  gnt_mode <= gnt_random;
  done_base = done_cnt;
  run_insn(op_vmnand, 300, 1'b1, 5'd25, 3'd5);
  assert (insn_ready_o) else
    abort_run($sformatf("Fail at %0t: insn_ready_o low after done", $time));
  // A single pulse per instruction
  repeat (6) @(negedge clk_i);
  assert (done_cnt == done_base + 1) else
    abort_run($sformatf("Fail at %0t: %0d done pulses, expected 1",
                        $time, done_cnt - done_base));
  @(posedge clk_i);
  fill_operands();
  run_insn(op_vmnor, 200, 1'b0, 5'd30, 3'd6);
  gnt_mode <= gnt_always;
endtask

`default_nettype wire

`endif

// File: dv/masku_tb.sv
`default_nettype none

module masku_tb;

  import masku_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Configuration
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned data_width    = 64;
  localparam int unsigned vlen          = 512;
  localparam int unsigned result_depth  = 2;
  localparam int unsigned words_per_reg = vlen / data_width;
  localparam int unsigned vl_width      = $clog2(vlen + 1);
  localparam int unsigned addr_width    = vreg_width + $clog2(words_per_reg);

  // LFSR seed and cycle limit of every wait
  localparam logic [15:0] lfsr_seed      = 16'd55874;
  localparam int          timeout_cycles = 300;

  // Register file grant behavior
  localparam int gnt_always = 0;
  localparam int gnt_hold   = 1;
  localparam int gnt_random = 2;

  ////////////////////////////////////////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////////////////////////////////////////

  logic                  clk_i;
  logic                  rst_ni;
  logic                  insn_valid_i;
  logic [op_width-1:0]   insn_op_i;
  logic [vl_width-1:0]   insn_vl_i;
  logic                  insn_vm_i;
  logic [vreg_width-1:0] insn_vd_i;
  logic [vid_width-1:0]  insn_id_i;
  logic                  insn_ready_o;
  logic                  opnd_valid_i;
  logic [data_width-1:0] opnd_vs2_i;
  logic [data_width-1:0] opnd_vs1_i;
  logic [data_width-1:0] opnd_old_i;
  logic [data_width-1:0] opnd_mask_i;
  logic                  opnd_ready_o;
  logic                  result_req_o;
  logic [addr_width-1:0] result_addr_o;
  logic [vid_width-1:0]  result_id_o;
  logic [data_width-1:0] result_wdata_o;
  logic                  result_gnt_i;
  logic                  done_o;
  logic [vid_width-1:0]  done_id_o;

  // Operand words of the current instruction by beat
  logic [data_width-1:0] vs2_a  [words_per_reg];
  logic [data_width-1:0] vs1_a  [words_per_reg];
  logic [data_width-1:0] old_a  [words_per_reg];
  logic [data_width-1:0] mask_a [words_per_reg];

  // Writes seen on the result port
  logic [addr_width-1:0] wr_addr_q [$];
  logic [vid_width-1:0]  wr_id_q   [$];
  logic [data_width-1:0] wr_data_q [$];

  // Event counters kept by the monitor
  int                    beat_cnt;
  int                    done_cnt;
  int                    writes_at_done;
  logic [vid_width-1:0]  last_done_id;

  logic [15:0]           lfsr_q;
  logic [15:0]           gnt_lfsr_q;
  int                    gnt_mode;

  masku_top #(
    .data_width  (data_width),
    .vlen        (vlen),
    .result_depth(result_depth)
  ) dut0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_valid_i  (insn_valid_i),
    .insn_op_i     (insn_op_i),
    .insn_vl_i     (insn_vl_i),
    .insn_vm_i     (insn_vm_i),
    .insn_vd_i     (insn_vd_i),
    .insn_id_i     (insn_id_i),
    .insn_ready_o  (insn_ready_o),
    .opnd_valid_i  (opnd_valid_i),
    .opnd_vs2_i    (opnd_vs2_i),
    .opnd_vs1_i    (opnd_vs1_i),
    .opnd_old_i    (opnd_old_i),
    .opnd_mask_i   (opnd_mask_i),
    .opnd_ready_o  (opnd_ready_o),
    .result_req_o  (result_req_o),
    .result_addr_o (result_addr_o),
    .result_id_o   (result_id_o),
    .result_wdata_o(result_wdata_o),
    .result_gnt_i  (result_gnt_i),
    .done_o        (done_o),
    .done_id_o     (done_id_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // 16-bit Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit of the word
  function automatic logic [data_width-1:0] rand_word();
    logic [data_width-1:0] w;
    for (int i = 0; i < data_width; i++) begin
      w[i]   = lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
    end
    return w;
  endfunction

  // Body bits enabled by the mask take the op and the rest keep the old value
  function automatic logic [data_width-1:0] ref_word(
    input logic [op_width-1:0]   op,
    input logic                  vm,
    input int                    rem,
    input logic [data_width-1:0] vs2,
    input logic [data_width-1:0] vs1,
    input logic [data_width-1:0] old,
    input logic [data_width-1:0] mask
  );
    logic [data_width-1:0] res;
    logic                  r;
    for (int i = 0; i < data_width; i++) begin
      case (op)
        op_vmandn: r = vs2[i] & !vs1[i];
        op_vmand:  r = vs2[i] & vs1[i];
        op_vmor:   r = vs2[i] | vs1[i];
        op_vmxor:  r = vs2[i] ^ vs1[i];
        op_vmorn:  r = vs2[i] | !vs1[i];
        op_vmnand: r = !(vs2[i] & vs1[i]);
        op_vmnor:  r = !(vs2[i] | vs1[i]);
        default:   r = (vs2[i] == vs1[i]);
      endcase
      res[i] = ((i < rem) && (vm || mask[i])) ? r : old[i];
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Register file model and monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    case (gnt_mode)
      gnt_always: result_gnt_i <= 1'b1;
      gnt_hold:   result_gnt_i <= 1'b0;
      default: begin
        result_gnt_i <= gnt_lfsr_q[0];
        gnt_lfsr_q = lfsr_step(gnt_lfsr_q);
      end
    endcase
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (result_req_o && result_gnt_i) begin
        wr_addr_q.push_back(result_addr_o);
        wr_id_q.push_back(result_id_o);
        wr_data_q.push_back(result_wdata_o);
      end
      if (opnd_valid_i && opnd_ready_o) begin
        beat_cnt++;
      end
      // Writes so far tell whether done came after the last grant
      if (done_o) begin
        done_cnt++;
        last_done_id   = done_id_o;
        writes_at_done = wr_data_q.size();
      end
    end
  end

  `include "masku_tests.svh"

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni         = 1'b0;
    insn_valid_i   = 1'b0;
    insn_op_i      = '0;
    insn_vl_i      = '0;
    insn_vm_i      = 1'b1;
    insn_vd_i      = '0;
    insn_id_i      = '0;
    opnd_valid_i   = 1'b0;
    opnd_vs2_i     = '0;
    opnd_vs1_i     = '0;
    opnd_old_i     = '0;
    opnd_mask_i    = '0;
    result_gnt_i   = 1'b0;
    gnt_mode       = gnt_always;
    lfsr_q         = lfsr_seed;
    gnt_lfsr_q     = lfsr_seed;
    beat_cnt       = 0;
    done_cnt       = 0;
    writes_at_done = 0;
    last_done_id   = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    test_reset_state();
    test_all_ops();
    test_tail();
    test_masking();
    test_back_pressure();
    test_done();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+dv
source/masku_pkg.sv
source/masku_decode.sv
source/masku_execute.sv
source/masku_result_queue.sv
source/masku_top.sv
dv/masku_checker.sv
dv/masku_tb.sv

// File: run.sh
#!/bin/sh
# Build the mask unit testbench and run it, the exit status carries the result
verilator --binary --timing --assert -j 0 \
  --top-module masku_tb -f flist.f -o masku_sim \
  && ./obj_dir/masku_sim \
  || exit 1

// File: source/masku_decode.sv
`default_nettype none

module masku_decode #(
  parameter int unsigned  data_width    = 64,
  parameter int unsigned  vlen          = 512,
  // Derived widths for the port list
  localparam int unsigned words_per_reg = vlen / data_width,
  localparam int unsigned vl_width      = $clog2(vlen + 1),
  localparam int unsigned addr_width    = masku_pkg::vreg_width + $clog2(words_per_reg),
  localparam int unsigned rem_width     = $clog2(data_width + 1)
) (
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  // Instruction port from the sequencer
  input  wire logic                             insn_valid_i,
  input  wire logic [masku_pkg::op_width-1:0]   insn_op_i,
  input  wire logic [vl_width-1:0]              insn_vl_i,
  input  wire logic                             insn_vm_i,
  input  wire logic [masku_pkg::vreg_width-1:0] insn_vd_i,
  input  wire logic [masku_pkg::vid_width-1:0]  insn_id_i,
  output logic                                  insn_ready_o,
  // Operand beat handshake
  input  wire logic                             opnd_valid_i,
  output logic                                  opnd_ready_o,
  // Controls for the execute stage
  output logic [masku_pkg::op_width-1:0]        op_o,
  output logic                                  vm_o,
  output logic [rem_width-1:0]                  rem_bits_o,
  // Push side of the result queue
  output logic                                  push_o,
  output logic [addr_width-1:0]                 push_addr_o,
  output logic [masku_pkg::vid_width-1:0]       push_id_o,
  output logic                                  push_last_o,
  input  wire logic                             push_ready_i,
  input  wire logic                             commit_last_i,
  // Completion pulse
  output logic                                  done_o,
  output logic [masku_pkg::vid_width-1:0]       done_id_o
);

  import masku_pkg::*;

  localparam int unsigned word_idx_width = (words_per_reg > 1) ? $clog2(words_per_reg) : 1;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction register
  ////////////////////////////////////////////////////////////////////////////

  // One instruction in flight at a time
  logic                      held_q;
  logic [op_width-1:0]       op_q;
  logic                      vm_q;
  logic [vreg_width-1:0]     vd_q;
  logic [vid_width-1:0]      id_q;

  // Bits still to issue, and the word being issued next
  logic [vl_width-1:0]       rem_q;
  logic [word_idx_width-1:0] word_idx_q;

  // Registered completion
  logic                      done_q;
  logic [vid_width-1:0]      done_id_q;

  logic                      insn_accept;
  logic                      beat;

  // Free exactly when nothing is held
  assign insn_ready_o = !held_q;
  assign insn_accept  = insn_valid_i && !held_q;

  // Fields load on acceptance and stay until the next one
  always_ff @(posedge clk_i) begin
    if (insn_accept) begin
      op_q <= insn_op_i;
      vm_q <= insn_vm_i;
      vd_q <= insn_vd_i;
      id_q <= insn_id_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Beat issue
  ////////////////////////////////////////////////////////////////////////////

  // Take a beat only when the queue can hold its result
  assign opnd_ready_o = held_q && (rem_q != '0) && push_ready_i;
  assign beat         = opnd_valid_i && opnd_ready_o;

  // Last word once the remaining bits fit in one word
  assign push_last_o  = (rem_q <= vl_width'(data_width));

  // Saturate so execute only sees up to one word of bits
  assign rem_bits_o   = (rem_q >= vl_width'(data_width)) ? rem_width'(data_width)
                                                         : rem_width'(rem_q);

  assign op_o        = op_q;
  assign vm_o        = vm_q;
  assign push_o      = beat;
  assign push_id_o   = id_q;
  // Destination word address inside the register file
  assign push_addr_o = addr_width'(vd_q) * addr_width'(words_per_reg)
                     + addr_width'(word_idx_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q     <= 1'b0;
      rem_q      <= '0;
      word_idx_q <= '0;
    end else if (insn_accept) begin
      held_q     <= 1'b1;
      rem_q      <= insn_vl_i;
      word_idx_q <= '0;
    end else begin
      if (beat) begin
        // Tail word drains the counter to zero
        rem_q      <= push_last_o ? '0 : rem_q - vl_width'(data_width);
        word_idx_q <= word_idx_q + word_idx_width'(1);
      end
      // Release the instruction once its last word is granted
      if (commit_last_i) begin
        held_q <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Done pulse
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else begin
      done_q <= commit_last_i;
    end
  end

  // Id sampled at the same edge as the pulse
  always_ff @(posedge clk_i) begin
    if (commit_last_i) begin
      done_id_q <= id_q;
    end
  end

  assign done_o    = done_q;
  assign done_id_o = done_id_q;

endmodule

`default_nettype wire

// File: source/masku_execute.sv
`default_nettype none

module masku_execute #(
  parameter int unsigned  data_width = 64,
  localparam int unsigned rem_width  = $clog2(data_width + 1)
) (
  // Instruction controls
  input  wire logic [masku_pkg::op_width-1:0] op_i,
  input  wire logic                           vm_i,
  input  wire logic [rem_width-1:0]           rem_bits_i,
  // One operand bundle
  input  wire logic [data_width-1:0]          vs2_i,
  input  wire logic [data_width-1:0]          vs1_i,
  input  wire logic [data_width-1:0]          old_i,
  input  wire logic [data_width-1:0]          mask_i,
  // Merged word for the destination
  output logic [data_width-1:0]               result_o
);

  import masku_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Bit enable
  ////////////////////////////////////////////////////////////////////////////

  logic [data_width-1:0] tail_en;
  logic [data_width-1:0] bit_en;
  logic [data_width-1:0] op_res;

  // Elements at or past vl stay untouched
  always_comb begin
    if (rem_bits_i >= rem_width'(data_width)) begin
      tail_en = '1;
    end else begin
      // Low rem_bits_i bits set
      tail_en = ~({data_width{1'b1}} << rem_bits_i);
    end
  end

  // Masked instruction also needs its mask bit set
  assign bit_en = vm_i ? tail_en : (tail_en & mask_i);

  ////////////////////////////////////////////////////////////////////////////
  // Mask-logical operation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (op_i)
      op_vmandn: op_res = vs2_i & ~vs1_i;
      op_vmand:  op_res = vs2_i & vs1_i;
      op_vmor:   op_res = vs2_i | vs1_i;
      op_vmxor:  op_res = vs2_i ^ vs1_i;
      op_vmorn:  op_res = vs2_i | ~vs1_i;
      op_vmnand: op_res = ~(vs2_i & vs1_i);
      op_vmnor:  op_res = ~(vs2_i | vs1_i);
      op_vmxnor: op_res = ~(vs2_i ^ vs1_i);
      default:   op_res = '0;
    endcase
  end

  // Enabled bits take the operation, the rest keep the old destination
  assign result_o = (op_res & bit_en) | (old_i & ~bit_en);

endmodule

`default_nettype wire

// File: source/masku_pkg.sv
`default_nettype none

package masku_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Operation codes
  ////////////////////////////////////////////////////////////////////////////

  // Width of the mask-logical operation code
  localparam int unsigned op_width = 3;

  // Mask-logical operations applied as vs2 <op> vs1
  localparam logic [op_width-1:0] op_vmandn = op_width'(0);
  localparam logic [op_width-1:0] op_vmand  = op_width'(1);
  localparam logic [op_width-1:0] op_vmor   = op_width'(2);
  localparam logic [op_width-1:0] op_vmxor  = op_width'(3);
  localparam logic [op_width-1:0] op_vmorn  = op_width'(4);
  localparam logic [op_width-1:0] op_vmnand = op_width'(5);
  localparam logic [op_width-1:0] op_vmnor  = op_width'(6);
  localparam logic [op_width-1:0] op_vmxnor = op_width'(7);

  ////////////////////////////////////////////////////////////////////////////
  // Identifier widths
  ////////////////////////////////////////////////////////////////////////////

  // Instruction id handed out by the sequencer
  localparam int unsigned vid_width = 3;

  // Vector register number for 32 architectural registers
  localparam int unsigned vreg_width = 5;

endpackage

`default_nettype wire

// File: source/masku_result_queue.sv
`default_nettype none

module masku_result_queue #(
  parameter int unsigned data_width   = 64,
  parameter int unsigned addr_width   = 8,
  parameter int unsigned result_depth = 2
) (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  // Push side from decode and execute
  input  wire logic                            push_i,
  input  wire logic [addr_width-1:0]           push_addr_i,
  input  wire logic [masku_pkg::vid_width-1:0] push_id_i,
  input  wire logic                            push_last_i,
  input  wire logic [data_width-1:0]           push_data_i,
  output logic                                 push_ready_o,
  // Pulses when the last word of an instruction is granted
  output logic                                 commit_last_o,
  // Register file write port
  output logic                                 result_req_o,
  output logic [addr_width-1:0]                result_addr_o,
  output logic [masku_pkg::vid_width-1:0]      result_id_o,
  output logic [data_width-1:0]                result_wdata_o,
  input  wire logic                            result_gnt_i
);

  import masku_pkg::*;

  localparam int unsigned ptr_width = (result_depth > 1) ? $clog2(result_depth) : 1;
  localparam int unsigned cnt_width = $clog2(result_depth + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  logic [addr_width-1:0] addr_mem [result_depth];
  logic [vid_width-1:0]  id_mem   [result_depth];
  logic [data_width-1:0] data_mem [result_depth];
  logic                  last_mem [result_depth];

  // Write into wr_ptr_q, read from rd_ptr_q
  logic [ptr_width-1:0]  wr_ptr_q;
  logic [ptr_width-1:0]  rd_ptr_q;
  // Entries waiting for a grant
  logic [cnt_width-1:0]  cnt_q;

  logic                  do_push;
  logic                  do_pop;

  // Circular increment that wraps after the last entry
  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    logic [ptr_width-1:0] nxt;
    if (ptr == ptr_width'(result_depth - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + ptr_width'(1);
    end
    return nxt;
  endfunction

  assign push_ready_o = (cnt_q != cnt_width'(result_depth));
  assign do_push      = push_i && push_ready_o;
  assign do_pop       = result_req_o && result_gnt_i;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      addr_mem[wr_ptr_q] <= push_addr_i;
      id_mem[wr_ptr_q]   <= push_id_i;
      data_mem[wr_ptr_q] <= push_data_i;
      last_mem[wr_ptr_q] <= push_last_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointers and count
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Simultaneous push and pop leave the count alone
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + cnt_width'(1);
        2'b01:   cnt_q <= cnt_q - cnt_width'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  // Head entry stays put until granted
  assign result_req_o   = (cnt_q != '0);
  assign result_addr_o  = addr_mem[rd_ptr_q];
  assign result_id_o    = id_mem[rd_ptr_q];
  assign result_wdata_o = data_mem[rd_ptr_q];

  // Last word of the instruction leaves the queue
  assign commit_last_o  = do_pop && last_mem[rd_ptr_q];

endmodule

`default_nettype wire

// File: source/masku_top.sv
`default_nettype none

module masku_top #(
  parameter int unsigned  data_width    = 64,
  parameter int unsigned  vlen          = 512,
  parameter int unsigned  result_depth  = 2,
  // Derived widths for the port list
  localparam int unsigned words_per_reg = vlen / data_width,
  localparam int unsigned vl_width      = $clog2(vlen + 1),
  localparam int unsigned addr_width    = masku_pkg::vreg_width + $clog2(words_per_reg)
) (
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  // Instruction port
  input  wire logic                             insn_valid_i,
  input  wire logic [masku_pkg::op_width-1:0]   insn_op_i,
  input  wire logic [vl_width-1:0]              insn_vl_i,
  input  wire logic                             insn_vm_i,
  input  wire logic [masku_pkg::vreg_width-1:0] insn_vd_i,
  input  wire logic [masku_pkg::vid_width-1:0]  insn_id_i,
  output logic                                  insn_ready_o,
  // Operand port from the lanes
  input  wire logic                             opnd_valid_i,
  input  wire logic [data_width-1:0]            opnd_vs2_i,
  input  wire logic [data_width-1:0]            opnd_vs1_i,
  input  wire logic [data_width-1:0]            opnd_old_i,
  input  wire logic [data_width-1:0]            opnd_mask_i,
  output logic                                  opnd_ready_o,
  // Register file write port
  output logic                                  result_req_o,
  output logic [addr_width-1:0]                 result_addr_o,
  output logic [masku_pkg::vid_width-1:0]       result_id_o,
  output logic [data_width-1:0]                 result_wdata_o,
  input  wire logic                             result_gnt_i,
  // Completion
  output logic                                  done_o,
  output logic [masku_pkg::vid_width-1:0]       done_id_o
);

  import masku_pkg::*;

  localparam int unsigned rem_width = $clog2(data_width + 1);

  // Decode to execute
  logic [op_width-1:0]   op;
  logic                  vm;
  logic [rem_width-1:0]  rem_bits;
  // Decode and execute to the result queue
  logic                  push;
  logic [addr_width-1:0] push_addr;
  logic [vid_width-1:0]  push_id;
  logic                  push_last;
  logic [data_width-1:0] exec_result;
  // Result queue back to decode
  logic                  push_ready;
  logic                  commit_last;

  masku_decode #(
    .data_width(data_width),
    .vlen      (vlen)
  ) u_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_valid_i (insn_valid_i),
    .insn_op_i    (insn_op_i),
    .insn_vl_i    (insn_vl_i),
    .insn_vm_i    (insn_vm_i),
    .insn_vd_i    (insn_vd_i),
    .insn_id_i    (insn_id_i),
    .insn_ready_o (insn_ready_o),
    .opnd_valid_i (opnd_valid_i),
    .opnd_ready_o (opnd_ready_o),
    .op_o         (op),
    .vm_o         (vm),
    .rem_bits_o   (rem_bits),
    .push_o       (push),
    .push_addr_o  (push_addr),
    .push_id_o    (push_id),
    .push_last_o  (push_last),
    .push_ready_i (push_ready),
    .commit_last_i(commit_last),
    .done_o       (done_o),
    .done_id_o    (done_id_o)
  );

  masku_execute #(
    .data_width(data_width)
  ) u_execute (
    .op_i      (op),
    .vm_i      (vm),
    .rem_bits_i(rem_bits),
    .vs2_i     (opnd_vs2_i),
    .vs1_i     (opnd_vs1_i),
    .old_i     (opnd_old_i),
    .mask_i    (opnd_mask_i),
    .result_o  (exec_result)
  );

  masku_result_queue #(
    .data_width  (data_width),
    .addr_width  (addr_width),
    .result_depth(result_depth)
  ) u_result_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .push_i        (push),
    .push_addr_i   (push_addr),
    .push_id_i     (push_id),
    .push_last_i   (push_last),
    .push_data_i   (exec_result),
    .push_ready_o  (push_ready),
    .commit_last_o (commit_last),
    .result_req_o  (result_req_o),
    .result_addr_o (result_addr_o),
    .result_id_o   (result_id_o),
    .result_wdata_o(result_wdata_o),
    .result_gnt_i  (result_gnt_i)
  );

endmodule

`default_nettype wire
